// File: hdl/x86_operand_pkg.sv
/*
 * Operand encodings for the operand stage of the decode pipeline.
 * Only the eight general registers are tracked; segment, MMX and
 * immediate operands never name a register here.
 * Size code 0 selects 8-bit operands, where indexes 4..7 are AH..BH.
 */
`default_nettype none

package x86_operand_pkg;

    localparam int REG_COUNT = 8;

    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
    typedef logic [1:0]                   reg_size_t;
    typedef logic [7:0]                   modrm_t;
    typedef logic [7:0]                   sib_t;
    typedef logic [1:0]                   mod_t;

    // operand kinds as delivered by the decoder
    typedef enum logic [2:0] {
        NONE  = 3'd0,
        REG   = 3'd1,
        SEG   = 3'd2,
        MMX   = 3'd3,
        MODRM = 3'd4,
        IMM   = 3'd5,
        MEM   = 3'd6
    } op_type_e;

    localparam mod_t      MOD_REGISTER = 2'd3;
    localparam reg_idx_t  RM_SIB       = 3'd4;
    localparam reg_idx_t  RM_DISP32    = 3'd5;
    localparam reg_idx_t  INDEX_NONE   = 3'd4;
    localparam reg_size_t SIZE_8       = 2'd0;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
    } reg_slot_t;

    typedef struct packed {
        reg_slot_t op0_r0;
        reg_slot_t op0_r1;
        reg_slot_t op1_r0;
        reg_slot_t op1_r1;
    } src_regs_t;

    typedef reg_slot_t dst_reg_t;

    // AH, CH, DH, BH live inside EAX, ECX, EDX, EBX
    function automatic reg_idx_t fold_high_byte(reg_idx_t idx, reg_size_t size);
        if (size == SIZE_8 && idx[2]) begin
            return {1'b0, idx[1:0]};
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// File: hdl/scoreboard_pkg.sv
/*
 * Pending-write table types.
 * Each register has one saturating-free counter of CNT_W bits, so at
 * most 15 writes to one register may be in flight.
 */
`default_nettype none

package scoreboard_pkg;

    localparam int CNT_W       = 4;
    localparam int TABLE_DEPTH = x86_operand_pkg::REG_COUNT;

    typedef logic [CNT_W-1:0] cnt_t;

    // entry i holds the count for register i
    typedef cnt_t [TABLE_DEPTH-1:0] cnt_table_t;

    localparam cnt_t CNT_MAX = '1;

    // writeback index is given at the writeback's own size
    typedef struct packed {
        logic                       valid;
        x86_operand_pkg::reg_idx_t  idx;
        x86_operand_pkg::reg_size_t size;
    } wb_t;

endpackage

`default_nettype wire

// File: hdl/operand_decode.sv
/*
 * Source and destination register extraction for op0 and op1.
 * The ModR/M reg field and the SIB scale are not looked at.
 * SIB base 101 with mod 00 is still treated as a base register.
 * Only register-direct indexes are folded by size; address registers
 * are always full 32-bit registers.
 */
`timescale 1ns/100ps
`default_nettype none

module operand_decode (
    input  x86_operand_pkg::op_type_e   op0,
    input  x86_operand_pkg::op_type_e   op1,
    input  x86_operand_pkg::reg_idx_t   op0_reg,
    input  x86_operand_pkg::reg_idx_t   op1_reg,
    input  x86_operand_pkg::modrm_t     mod_rm,
    input  x86_operand_pkg::sib_t       sib,
    input  x86_operand_pkg::reg_size_t  register_size,
    output x86_operand_pkg::src_regs_t  src,
    output x86_operand_pkg::dst_reg_t   dst
);
    import x86_operand_pkg::*;

    // the two registers one operand can read
    typedef struct packed {
        reg_slot_t r0;
        reg_slot_t r1;
    } op_srcs_t;

    mod_t     mod;
    reg_idx_t rm;
    reg_idx_t sib_base;
    reg_idx_t sib_index;
    logic     rm_direct;
    logic     uses_sib;
    logic     disp_only;
    reg_idx_t rm_reg;
    op_srcs_t op0_srcs;
    op_srcs_t op1_srcs;

    assign mod       = mod_rm[7:6];
    assign rm        = mod_rm[2:0];
    assign sib_base  = sib[2:0];
    assign sib_index = sib[5:3];

    // mod 11 names a register, not memory
    assign rm_direct = (mod == MOD_REGISTER);
    assign uses_sib  = !rm_direct && (rm == RM_SIB);
    // mod 00 r/m 101 is a plain disp32, no base register
    assign disp_only = (mod == 2'b00) && (rm == RM_DISP32);

    // register read through r/m
    always_comb begin
        if (rm_direct) begin
            rm_reg = fold_high_byte(rm, register_size);
        end else if (uses_sib) begin
            rm_reg = sib_base;
        end else begin
            rm_reg = rm;
        end
    end

    function automatic op_srcs_t decode_operand(op_type_e op, reg_idx_t op_reg);
        op_srcs_t s;
        s = '0;
        case (op)
            REG: begin
                s.r0.valid = 1'b1;
                s.r0.idx   = fold_high_byte(op_reg, register_size);
            end
            MEM: begin
                // address register, always full width
                s.r0.valid = 1'b1;
                s.r0.idx   = op_reg;
            end
            MODRM: begin
                s.r0.valid = !disp_only;
                s.r0.idx   = rm_reg;
                // index 100 means no index register
                s.r1.valid = uses_sib && (sib_index != INDEX_NONE);
                s.r1.idx   = sib_index;
            end
            default: begin
                // SEG, MMX, IMM and NONE read no general register
                s = '0;
            end
        endcase
        return s;
    endfunction

    always_comb begin
        op0_srcs = decode_operand(op0, op0_reg);
        op1_srcs = decode_operand(op1, op1_reg);
    end

    always_comb begin
        src.op0_r0 = op0_srcs.r0;
        src.op0_r1 = op0_srcs.r1;
        src.op1_r0 = op1_srcs.r0;
        src.op1_r1 = op1_srcs.r1;
    end

    // op0 writes a register when it is one, or r/m in register mode
    always_comb begin
        dst.valid = (op0 == REG) || ((op0 == MODRM) && rm_direct);
        if (op0 == REG) begin
            dst.idx = fold_high_byte(op0_reg, register_size);
        end else begin
            dst.idx = fold_high_byte(rm, register_size);
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_scoreboard.sv
/*
 * Eight pending-write counters, one per general register.
 * Issue with a valid destination counts up, a valid writeback counts
 * down; both on one register in one cycle leave it unchanged.
 * Counters do not saturate, the producer must keep within 15.
 */
`timescale 1ns/100ps
`default_nettype none

module reg_scoreboard (
    input  wire                         clk,
    input  wire                         rst_n,
    input  logic                        issue,
    input  x86_operand_pkg::dst_reg_t   dst,
    input  scoreboard_pkg::wb_t         wb,
    output scoreboard_pkg::cnt_table_t  counts
);
    import x86_operand_pkg::*;
    import scoreboard_pkg::*;

    reg_idx_t               wb_idx;
    logic [TABLE_DEPTH-1:0] inc;
    logic [TABLE_DEPTH-1:0] dec;

    // an 8-bit BH writeback retires a write to EBX
    assign wb_idx = fold_high_byte(wb.idx, wb.size);

    always_comb begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            inc[i] = issue && dst.valid && (dst.idx == reg_idx_t'(i));
            dec[i] = wb.valid && (wb_idx == reg_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                if (inc[i] && !dec[i]) begin
                    counts[i] <= counts[i] + cnt_t'(1);
                end else if (dec[i] && !inc[i]) begin
                    counts[i] <= counts[i] - cnt_t'(1);
                end
            end
        end
    end

    for (genvar g = 0; g < TABLE_DEPTH; g++) begin : g_bounds
        // more than 15 writes in flight would wrap to zero and hide a hazard
        a_no_overflow : assert property (
            @(posedge clk) disable iff (!rst_n)
            (inc[g] && !dec[g]) |-> (counts[g] != CNT_MAX)
        ) else $error("pending-write counter %0d overflow", g);

        // a writeback with nothing in flight points at a pipeline bug
        a_no_underflow : assert property (
            @(posedge clk) disable iff (!rst_n)
            (dec[g] && !inc[g]) |-> (counts[g] != '0)
        ) else $error("pending-write counter %0d underflow", g);
    end

endmodule

`default_nettype wire

// File: hdl/hazard_check.sv
/*
 * Stall and issue for the instruction in the operand stage.
 * Purely combinational; a count written on one edge is seen from the
 * following cycle. issue needs instr_valid, next_stage_ready and no
 * stall in the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module hazard_check (
    input  wire                         instr_valid,
    input  wire                         next_stage_ready,
    input  x86_operand_pkg::src_regs_t  src,
    input  scoreboard_pkg::cnt_table_t  counts,
    output logic                        stall,
    output logic                        issue
);
    import x86_operand_pkg::*;
    import scoreboard_pkg::*;

    logic [3:0] busy;

    // a slot is busy when it reads a register with writes in flight
    function automatic logic slot_busy(reg_slot_t slot, cnt_table_t cnt_in);
        return slot.valid && (cnt_in[slot.idx] != '0);
    endfunction

    assign busy[0] = slot_busy(src.op0_r0, counts);
    assign busy[1] = slot_busy(src.op0_r1, counts);
    assign busy[2] = slot_busy(src.op1_r0, counts);
    assign busy[3] = slot_busy(src.op1_r1, counts);

    assign stall = instr_valid && (|busy);
    assign issue = instr_valid && next_stage_ready && !stall;

endmodule

`default_nettype wire

// File: hdl/reg_stall_top.sv
/*
 * Register stall logic for the operand stage.
 * stall and issue are combinational from the instruction fields;
 * the table changes on the edge after an issue or a writeback.
 * Inputs must be held by the upstream until issue is seen high.
 */
`timescale 1ns/100ps
`default_nettype none

module reg_stall_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         instr_valid,
    input  x86_operand_pkg::op_type_e   op0,
    input  x86_operand_pkg::op_type_e   op1,
    input  x86_operand_pkg::reg_idx_t   op0_reg,
    input  x86_operand_pkg::reg_idx_t   op1_reg,
    input  x86_operand_pkg::modrm_t     mod_rm,
    input  x86_operand_pkg::sib_t       sib,
    input  x86_operand_pkg::reg_size_t  register_size,
    input  scoreboard_pkg::wb_t         wb,
    input  wire                         next_stage_ready,
    output logic                        stall,
    output logic                        issue
);
    import x86_operand_pkg::*;
    import scoreboard_pkg::*;

    src_regs_t  src;
    dst_reg_t   dst;
    cnt_table_t counts;

    operand_decode u_decode (
        .op0           (op0),
        .op1           (op1),
        .op0_reg       (op0_reg),
        .op1_reg       (op1_reg),
        .mod_rm        (mod_rm),
        .sib           (sib),
        .register_size (register_size),
        .src           (src),
        .dst           (dst)
    );

    reg_scoreboard u_table (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .dst    (dst),
        .wb     (wb),
        .counts (counts)
    );

    hazard_check u_hazard (
        .instr_valid      (instr_valid),
        .next_stage_ready (next_stage_ready),
        .src              (src),
        .counts           (counts),
        .stall            (stall),
        .issue            (issue)
    );

endmodule

`default_nettype wire

// File: sim/stall_checker.sv
/*
 * Watches the DUT ports and compares stall and issue with the table.
 * Keeps its own pending-write counts, decoded from the instruction
 * fields by the operand rules, and checks them against the table too.
 * Sampled on the falling edge, where inputs and outputs are settled.
 */
`timescale 1ns/100ps
`default_nettype none

module stall_checker (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         check_en,
    input  wire [127:0]                 test_name,
    input  wire                         exp_stall,
    input  wire                         exp_issue,
    input  wire                         instr_valid,
    input  x86_operand_pkg::op_type_e   op0,
    input  x86_operand_pkg::op_type_e   op1,
    input  x86_operand_pkg::reg_idx_t   op0_reg,
    input  x86_operand_pkg::reg_idx_t   op1_reg,
    input  x86_operand_pkg::modrm_t     mod_rm,
    input  x86_operand_pkg::sib_t       sib,
    input  x86_operand_pkg::reg_size_t  register_size,
    input  scoreboard_pkg::wb_t         wb,
    input  wire                         next_stage_ready,
    input  wire                         stall,
    input  wire                         issue,
    output int                          value_errors,
    output int                          model_errors
);
    import x86_operand_pkg::*;
    import scoreboard_pkg::*;

    localparam int NAME_W = 128;

    int   model_cnt [REG_COUNT];
    logic model_stall;
    logic model_issue;

    // names are packed right-aligned, skip the zero bytes in front
    function automatic string name_text(logic [NAME_W-1:0] v);
        string s;
        s = "";
        for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
            if (v[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", v[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    // 8-bit size maps AH..BH onto EAX..EBX
    function automatic reg_idx_t fold_reg(reg_idx_t idx, reg_size_t size);
        if (size == 2'd0 && idx >= 3'd4) begin
            return idx - 3'd4;
        end
        return idx;
    endfunction

    // true when the operand reads a register with writes in flight
    function automatic logic operand_waits(op_type_e op, reg_idx_t r);
        case (op)
            REG: return model_cnt[fold_reg(r, register_size)] != 0;
            MEM: return model_cnt[r] != 0;
            MODRM: begin
                if (mod_rm[7:6] == 2'd3) begin
                    return model_cnt[fold_reg(mod_rm[2:0], register_size)] != 0;
                end
                if (mod_rm[2:0] == 3'd4) begin
                    return (model_cnt[sib[2:0]] != 0) ||
                           (sib[5:3] != 3'd4 && model_cnt[sib[5:3]] != 0);
                end
                if (mod_rm[7:6] == 2'd0 && mod_rm[2:0] == 3'd5) begin
                    return 1'b0;
                end
                return model_cnt[mod_rm[2:0]] != 0;
            end
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_bit(input string what, input logic expected, input logic actual,
                             input logic is_model);
        if (actual !== expected) begin
            $display("Fail %0s %0s: expected %0b, actual %0b",
                     name_text(test_name), what, expected, actual);
            if (is_model) begin
                model_errors++;
            end else begin
                value_errors++;
            end
        end
    endtask

    // count changes that the next rising edge makes in the table
    task automatic book_edge();
        logic     dst_ok;
        reg_idx_t dst_r;
        reg_idx_t wb_r;
        dst_ok = (op0 == REG) || (op0 == MODRM && mod_rm[7:6] == 2'd3);
        dst_r  = (op0 == REG) ? fold_reg(op0_reg, register_size)
                              : fold_reg(mod_rm[2:0], register_size);
        wb_r   = fold_reg(wb.idx, wb.size);
        if (issue && dst_ok) begin
            model_cnt[dst_r]++;
        end
        if (wb.valid) begin
            if (model_cnt[wb_r] == 0) begin
                $display("writeback of register %0d in test %0s has no write in flight",
                         wb_r, name_text(test_name));
                model_errors++;
            end
            model_cnt[wb_r]--;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            foreach (model_cnt[i]) begin
                model_cnt[i] = 0;
            end
            value_errors = 0;
            model_errors = 0;
        end else if (check_en) begin
            model_stall = instr_valid &&
                          (operand_waits(op0, op0_reg) || operand_waits(op1, op1_reg));
            model_issue = instr_valid && next_stage_ready && !model_stall;
            check_bit("stall", exp_stall, stall, 1'b0);
            check_bit("issue", exp_issue, issue, 1'b0);
            check_bit("model stall", exp_stall, model_stall, 1'b1);
            check_bit("model issue", exp_issue, model_issue, 1'b1);
            book_edge();
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_reg_stall.sv
/*
 * Testbench for the operand-stage register stall logic.
 * One table row is applied per clock; stall and issue are checked
 * in the same cycle by the checker module.
 * Test names are limited to 16 characters.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_reg_stall;
    import x86_operand_pkg::*;
    import scoreboard_pkg::*;

    localparam int NAME_W       = 128;
    localparam int RESET_CYCLES = 4;
    localparam int S8           = 0;
    localparam int S32          = 3;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        logic              instr_valid;
        op_type_e          op0;
        reg_idx_t          op0_reg;
        op_type_e          op1;
        reg_idx_t          op1_reg;
        modrm_t            mod_rm;
        sib_t              sib;
        reg_size_t         size;
        wb_t               wb;
        logic              ready;
        logic              exp_stall;
        logic              exp_issue;
    } row_t;

    row_t rows [$];

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    op_type_e          op0;
    op_type_e          op1;
    reg_idx_t          op0_reg;
    reg_idx_t          op1_reg;
    modrm_t            mod_rm;
    sib_t              sib;
    reg_size_t         register_size;
    wb_t               wb;
    logic              next_stage_ready;
    logic              stall;
    logic              issue;
    logic              check_en;
    logic [NAME_W-1:0] cur_name;
    logic              exp_stall;
    logic              exp_issue;
    int                value_errors;
    int                model_errors;
    int                cycle_count = 0;
    int                limit;

    reg_stall_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_valid      (instr_valid),
        .op0              (op0),
        .op1              (op1),
        .op0_reg          (op0_reg),
        .op1_reg          (op1_reg),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .register_size    (register_size),
        .wb               (wb),
        .next_stage_ready (next_stage_ready),
        .stall            (stall),
        .issue            (issue)
    );

    stall_checker u_check (
        .clk              (clk),
        .rst_n            (rst_n),
        .check_en         (check_en),
        .test_name        (cur_name),
        .exp_stall        (exp_stall),
        .exp_issue        (exp_issue),
        .instr_valid      (instr_valid),
        .op0              (op0),
        .op1              (op1),
        .op0_reg          (op0_reg),
        .op1_reg          (op1_reg),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .register_size    (register_size),
        .wb               (wb),
        .next_stage_ready (next_stage_ready),
        .stall            (stall),
        .issue            (issue),
        .value_errors     (value_errors),
        .model_errors     (model_errors)
    );

    function automatic logic [NAME_W-1:0] pack_name(string s);
        logic [NAME_W-1:0] v;
        v = '0;
        for (int i = 0; i < s.len() && i < NAME_W / 8; i++) begin
            v = {v[NAME_W-9:0], s[i]};
        end
        return v;
    endfunction

    task automatic add_row(input string name, input int valid, input op_type_e o0, input int r0,
                           input op_type_e o1, input int r1, input modrm_t mrm, input sib_t sb,
                           input int size, input int wbv, input int wbr, input int wbs,
                           input int rdy, input int stl, input int iss);
        row_t r;
        r.name        = pack_name(name);
        r.instr_valid = (valid != 0);
        r.op0         = o0;
        r.op0_reg     = reg_idx_t'(r0);
        r.op1         = o1;
        r.op1_reg     = reg_idx_t'(r1);
        r.mod_rm      = mrm;
        r.sib         = sb;
        r.size        = reg_size_t'(size);
        r.wb.valid    = (wbv != 0);
        r.wb.idx      = reg_idx_t'(wbr);
        r.wb.size     = reg_size_t'(wbs);
        r.ready       = (rdy != 0);
        r.exp_stall   = (stl != 0);
        r.exp_issue   = (iss != 0);
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r, input logic checked);
        check_en         <= checked;
        cur_name         <= r.name;
        instr_valid      <= r.instr_valid;
        op0              <= r.op0;
        op0_reg          <= r.op0_reg;
        op1              <= r.op1;
        op1_reg          <= r.op1_reg;
        mod_rm           <= r.mod_rm;
        sib              <= r.sib;
        register_size    <= r.size;
        wb               <= r.wb;
        next_stage_ready <= r.ready;
        exp_stall        <= r.exp_stall;
        exp_issue        <= r.exp_issue;
    endtask

    task automatic build_table();
        // name, valid, op0, reg, op1, reg, mod_rm, sib, size, wb v/reg/size, ready, stall, issue
        add_row("idle", 0, NONE, 0, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 0);
        add_row("rd_r0", 1, NONE, 0, REG, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("rd_r7", 1, NONE, 0, REG, 7, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("wr_r3", 1, REG, 3, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("rd_r3_stall", 1, NONE, 0, REG, 3, 8'h00, 8'h00, S32, 0, 0, S32, 1, 1, 0);
        add_row("wb_r3", 1, NONE, 0, REG, 3, 8'h00, 8'h00, S32, 1, 3, S32, 1, 1, 0);
        add_row("rd_r3_clear", 1, NONE, 0, REG, 3, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        // BH write pends on EBX
        add_row("wr_bh", 1, REG, 7, NONE, 0, 8'h00, 8'h00, S8, 0, 0, S32, 1, 0, 1);
        add_row("rd_ebx_stall", 1, NONE, 0, REG, 3, 8'h00, 8'h00, S32, 0, 0, S32, 1, 1, 0);
        add_row("wb_bh", 1, NONE, 0, REG, 3, 8'h00, 8'h00, S32, 1, 7, S8, 1, 1, 0);
        add_row("rd_ebx_clear", 1, NONE, 0, REG, 3, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        // registers 4 and 5 pending for the ModR/M and SIB rows
        add_row("wr_r5", 1, REG, 5, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("disp32_only", 1, NONE, 0, MODRM, 0, 8'h05, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("rm_r5_stall", 1, NONE, 0, MODRM, 0, 8'h45, 8'h00, S32, 0, 0, S32, 1, 1, 0);
        add_row("wr_r4", 1, REG, 4, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("sib_no_index", 1, NONE, 0, MODRM, 0, 8'h44, 8'h20, S32, 0, 0, S32, 1, 0, 1);
        add_row("sib_base_stall", 1, NONE, 0, MODRM, 0, 8'h44, 8'h25, S32, 0, 0, S32, 1, 1, 0);
        add_row("sib_index_stall", 1, NONE, 0, MODRM, 0, 8'h44, 8'h28, S32, 0, 0, S32, 1, 1, 0);
        add_row("mem_r4_stall", 1, NONE, 0, MEM, 4, 8'h00, 8'h00, S32, 0, 0, S32, 1, 1, 0);
        add_row("mem_size8_stall", 1, NONE, 0, MEM, 4, 8'h00, 8'h00, S8, 0, 0, S32, 1, 1, 0);
        add_row("reg_ah_fold", 1, NONE, 0, REG, 4, 8'h00, 8'h00, S8, 0, 0, S32, 1, 0, 1);
        add_row("wb_r4", 0, NONE, 0, NONE, 0, 8'h00, 8'h00, S32, 1, 4, S32, 1, 0, 0);
        add_row("wb_r5", 0, NONE, 0, NONE, 0, 8'h00, 8'h00, S32, 1, 5, S32, 1, 0, 0);
        // issue and writeback on one edge
        add_row("wr_wb_same", 1, REG, 2, NONE, 0, 8'h00, 8'h00, S32, 1, 2, S32, 1, 0, 1);
        add_row("rd_r2_free", 1, NONE, 0, REG, 2, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("wr_r2", 1, REG, 2, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("wr_r6_wb_r2", 1, REG, 6, NONE, 0, 8'h00, 8'h00, S32, 1, 2, S32, 1, 0, 1);
        add_row("rd_r2_clear", 1, NONE, 0, REG, 2, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("rm_r6_stall", 1, NONE, 0, MODRM, 0, 8'hC6, 8'h00, S32, 1, 6, S32, 1, 1, 0);
        add_row("rm_r6_clear", 1, NONE, 0, MODRM, 0, 8'hC6, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        // back-pressure
        add_row("wr_r1_blocked", 1, REG, 1, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 0, 0, 0);
        add_row("rd_r1_free", 1, NONE, 0, REG, 1, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("wr_r1", 1, REG, 1, NONE, 0, 8'h00, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("rd_r1_blocked", 1, NONE, 0, REG, 1, 8'h00, 8'h00, S32, 0, 0, S32, 0, 1, 0);
        add_row("wb_r1", 0, NONE, 0, NONE, 0, 8'h00, 8'h00, S32, 1, 1, S32, 1, 0, 0);
        add_row("wr_modrm_r1", 1, MODRM, 0, NONE, 0, 8'hC1, 8'h00, S32, 0, 0, S32, 1, 0, 1);
        add_row("rd_r1_stall", 1, NONE, 0, REG, 1, 8'h00, 8'h00, S32, 0, 0, S32, 1, 1, 0);
        add_row("wb_r1_late", 0, NONE, 0, NONE, 0, 8'h00, 8'h00, S32, 1, 1, S32, 1, 0, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ends a run that stops making progress
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= limit) begin
            $display("timeout: no result after %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        build_table();
        limit = rows.size() + 20;
        apply_row(rows[0], 1'b0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            @(posedge clk);
            apply_row(rows[i], 1'b1);
        end
        @(posedge clk);
        apply_row(rows[0], 1'b0);
        @(posedge clk);
        $display("errors: %0d DUT mismatches, %0d model mismatches", value_errors, model_errors);
        if (value_errors == 0 && model_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/x86_operand_pkg.sv
hdl/scoreboard_pkg.sv
hdl/operand_decode.sv
hdl/reg_scoreboard.sv
hdl/hazard_check.sv
hdl/reg_stall_top.sv
sim/stall_checker.sv
sim/tb_reg_stall.sv

// File: Makefile
# Verilator build and run of the register stall testbench

OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_reg_stall \
		-f build.f --Mdir $(OBJ) -o sim_reg_stall

run: compile
	./$(OBJ)/sim_reg_stall | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf $(OBJ) sim.log
